// ==== logic/board_pkg.sv ====
//----------------------------
// Board control package
// Widths, timing constants and the
// control and status word layouts
//----------------------------
`default_nettype none

package board_pkg;

    // Input widths
    localparam int BTN_W = 2;
    localparam int CFG_W = 2;

    // Timing on the 27 MHz reference
    localparam int CLK27_TICKS_PER_MS = 27000;
    localparam int MS_CTR_W = 15;
    localparam int WARN_CTR_W = 24;

    // Backlight timeout thresholds in milliseconds
    localparam logic [MS_CTR_W-1:0] BL_MS_3S = 15'd3000;
    localparam logic [MS_CTR_W-1:0] BL_MS_10S = 15'd10000;
    localparam logic [MS_CTR_W-1:0] BL_MS_30S = 15'd30000;

    // Backlight timeout setting
    typedef logic [1:0] bl_time_t;

    localparam bl_time_t BL_TIME_OFF = 2'd0;
    localparam bl_time_t BL_TIME_3S = 2'd1;
    localparam bl_time_t BL_TIME_10S = 2'd2;
    localparam bl_time_t BL_TIME_30S = 2'd3;

    // CPU system control word, bit 0 is hw_reset_n
    typedef struct packed {
        logic [22:0] reserved;
        logic        remote_event;
        logic        sd_ss_n;
        logic        lcd_cs_n;
        logic        lcd_rs;
        logic        lcd_bl_on;
        bl_time_t    lcd_bl_time;
        logic        enable_sc;
        logic        hw_reset_n;
    } sys_ctrl_t;

    // Status word read back by the CPU
    typedef struct packed {
        logic             vsync_flag;
        logic             pll_activeclock;
        logic             cfg0;
        logic [BTN_W-1:0] btn;
    } status_t;

endpackage

`default_nettype wire

// ==== logic/ctrl_sync_if.sv ====
//----------------------------
// Synchronized board inputs
// From input_sync to its consumers
//----------------------------
`timescale 1ns/1ps
`default_nettype none

interface ctrl_sync_if import board_pkg::*; ();

    logic [BTN_W-1:0] btn;
    logic [CFG_W-1:0] cfg;
    // Inverted vertical sync, high during active video
    logic             vsync_flag;
    // One cycle per resync event
    logic             resync_rise;

    modport src (
        output btn, cfg, vsync_flag, resync_rise
    );

    modport dst (
        input btn, cfg, vsync_flag, resync_rise
    );

endinterface

`default_nettype wire

// ==== logic/input_sync.sv ====
//----------------------------
// Input synchronizers
// Button and vsync synchronizers, strap
// latch and resync edge detection
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module input_sync import board_pkg::*; (
    input  wire logic             clk27,
    input  wire logic             po_reset_n,
    input  wire logic [BTN_W-1:0] btn_i,
    input  wire logic [CFG_W-1:0] cfg_i,
    input  wire logic             vsync_i,
    input  wire logic             resync_strobe_i,
    ctrl_sync_if.src              sync
);

    logic [BTN_W-1:0] btn_meta;
    logic             vsync_meta;
    logic             cfg_stored;
    logic             resync_meta;
    logic             resync_sync;
    logic             resync_prev;

    // Buttons and vsync, two flops each
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_meta <= '0;
            sync.btn <= '0;
            vsync_meta <= 1'b0;
            sync.vsync_flag <= 1'b0;
        end else begin
            btn_meta <= btn_i;
            sync.btn <= btn_meta;
            // Inverted on the way in
            vsync_meta <= ~vsync_i;
            sync.vsync_flag <= vsync_meta;
        end
    end

    // Straps are taken once, on the first clock out of reset
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cfg_stored <= 1'b0;
            sync.cfg <= '0;
        end else begin
            if (!cfg_stored)
                sync.cfg <= cfg_i;
            cfg_stored <= 1'b1;
        end
    end

    // Resync strobe comes from another clock domain
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            resync_meta <= 1'b0;
            resync_sync <= 1'b0;
            resync_prev <= 1'b0;
            sync.resync_rise <= 1'b0;
        end else begin
            resync_meta <= resync_strobe_i;
            resync_sync <= resync_meta;
            resync_prev <= resync_sync;
            sync.resync_rise <= resync_sync & ~resync_prev;
        end
    end

endmodule

`default_nettype wire

// ==== logic/backlight_timer.sv ====
//----------------------------
// LCD backlight timer
// Counts milliseconds since the last
// remote event, flags the timeout
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module backlight_timer import board_pkg::*; #(
    parameter int TICKS_PER_MS = CLK27_TICKS_PER_MS
) (
    input  wire logic     clk27,
    input  wire logic     po_reset_n,
    input  wire logic     remote_event_i,
    input  wire bl_time_t bl_time_i,
    output logic          bl_timeout_o
);

    localparam int PRE_W = $clog2(TICKS_PER_MS + 1);
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICKS_PER_MS - 1);

    logic [PRE_W-1:0]    pre_ctr;
    logic [MS_CTR_W-1:0] ms_ctr;
    logic                remote_event_prev;

    // Prescaler and saturating ms counter, restarted by any remote event
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pre_ctr <= '0;
            ms_ctr <= '0;
            remote_event_prev <= 1'b0;
        end else begin
            remote_event_prev <= remote_event_i;
            if (remote_event_i != remote_event_prev) begin
                pre_ctr <= '0;
                ms_ctr <= '0;
            end else if (pre_ctr == PRE_LAST) begin
                pre_ctr <= '0;
                if (ms_ctr != '1)
                    ms_ctr <= ms_ctr + 1'b1;
            end else begin
                pre_ctr <= pre_ctr + 1'b1;
            end
        end
    end

    // Compare against the selected threshold
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            bl_timeout_o <= 1'b0;
        end else begin
            case (bl_time_i)
                BL_TIME_3S:  bl_timeout_o <= (ms_ctr >= BL_MS_3S);
                BL_TIME_10S: bl_timeout_o <= (ms_ctr >= BL_MS_10S);
                BL_TIME_30S: bl_timeout_o <= (ms_ctr >= BL_MS_30S);
                // Off never times out
                default:     bl_timeout_o <= 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/sync_warn.sv ====
//----------------------------
// Sync-loss warning
// Hold counters that stretch resync
// events and PLL lock loss
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module sync_warn import board_pkg::*; #(
    parameter int CTR_W = WARN_CTR_W
) (
    input  wire logic clk27,
    input  wire logic po_reset_n,
    input  wire logic enable_sc_i,
    input  wire logic pll_locked_i,
    input  wire logic pll_areset_i,
    ctrl_sync_if.dst  sync,
    output logic      warn_active_o
);

    logic [CTR_W-1:0] resync_ctr;
    logic [CTR_W-1:0] pll_ctr;

    // Resync hold, frozen while scaling is disabled
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            resync_ctr <= '0;
        end else if (enable_sc_i) begin
            if (sync.resync_rise)
                resync_ctr <= '1;
            else if (resync_ctr != '0)
                resync_ctr <= resync_ctr - 1'b1;
        end
    end

    // PLL lock loss hold
    // Parked at 1 while unlocked, then runs up until it wraps to zero
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pll_ctr <= '0;
        end else begin
            if (!pll_areset_i && !pll_locked_i)
                pll_ctr <= CTR_W'(1);
            else if (pll_ctr != '0)
                pll_ctr <= pll_ctr + 1'b1;
        end
    end

    assign warn_active_o = (resync_ctr != '0) | (pll_ctr != '0);

endmodule

`default_nettype wire

// ==== logic/panel_status.sv ====
//----------------------------
// Panel status
// LED drive, CPU status word and PLL
// reference switch request
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module panel_status import board_pkg::*; (
    input  wire logic clk27,
    input  wire logic po_reset_n,
    input  wire logic warn_active_i,
    input  wire logic enable_sc_i,
    input  wire logic pll_activeclock_i,
    ctrl_sync_if.dst  sync,
    output logic      led_r_o,
    output logic      led_g_o,
    output status_t   status_o,
    output logic      pll_clkswitch_o
);

    // Red shows any warning
    assign led_r_o = warn_active_i;

    // Strap bit 1 keeps green lit regardless of warnings
    assign led_g_o = ~warn_active_i | sync.cfg[1];

    always_comb begin
        status_o.btn = sync.btn;
        status_o.cfg0 = sync.cfg[0];
        status_o.pll_activeclock = pll_activeclock_i;
        status_o.vsync_flag = sync.vsync_flag;
    end

    // Request a reference switch whenever the active clock differs
    // from the one implied by enable_sc
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pll_clkswitch_o <= 1'b0;
        end else begin
            pll_clkswitch_o <= (pll_activeclock_i != enable_sc_i);
        end
    end

endmodule

`default_nettype wire

// ==== logic/board_ctrl.sv ====
//----------------------------
// Board control top level
// Decodes the CPU control word, drives
// LEDs, backlight and PLL switchover
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module board_ctrl import board_pkg::*; #(
    parameter int TICKS_PER_MS = CLK27_TICKS_PER_MS,
    parameter int WARN_W = WARN_CTR_W
) (
    input  wire logic             clk27,
    input  wire logic             po_reset_n,
    input  wire logic [31:0]      sys_ctrl_i,
    input  wire logic [BTN_W-1:0] btn_i,
    input  wire logic [CFG_W-1:0] cfg_i,
    input  wire logic             vsync_i,
    input  wire logic             resync_strobe_i,
    input  wire logic             pll_locked_i,
    input  wire logic             pll_areset_i,
    input  wire logic             pll_activeclock_i,
    output status_t               status_o,
    output logic                  led_r_o,
    output logic                  led_g_o,
    output logic                  lcd_bl_o,
    output logic                  lcd_cs_n_o,
    output logic                  lcd_rs_o,
    output logic                  sd_ss_n_o,
    output logic                  hw_reset_n_o,
    output logic                  pll_clkswitch_o
);

    sys_ctrl_t ctrl;
    logic      bl_timeout;
    logic      warn_active;

    ctrl_sync_if sync_if ();

    assign ctrl = sys_ctrl_t'(sys_ctrl_i);

    // Direct decode of the control word
    assign lcd_cs_n_o = ctrl.lcd_cs_n;
    assign lcd_rs_o = ctrl.lcd_rs;
    assign sd_ss_n_o = ctrl.sd_ss_n;
    assign hw_reset_n_o = ctrl.hw_reset_n;
    assign lcd_bl_o = ctrl.lcd_bl_on & ~bl_timeout;

    input_sync u_input_sync (
        .clk27           (clk27),
        .po_reset_n      (po_reset_n),
        .btn_i           (btn_i),
        .cfg_i           (cfg_i),
        .vsync_i         (vsync_i),
        .resync_strobe_i (resync_strobe_i),
        .sync            (sync_if.src)
    );

    backlight_timer #(
        .TICKS_PER_MS (TICKS_PER_MS)
    ) u_backlight_timer (
        .clk27          (clk27),
        .po_reset_n     (po_reset_n),
        .remote_event_i (ctrl.remote_event),
        .bl_time_i      (ctrl.lcd_bl_time),
        .bl_timeout_o   (bl_timeout)
    );

    sync_warn #(
        .CTR_W (WARN_W)
    ) u_sync_warn (
        .clk27         (clk27),
        .po_reset_n    (po_reset_n),
        .enable_sc_i   (ctrl.enable_sc),
        .pll_locked_i  (pll_locked_i),
        .pll_areset_i  (pll_areset_i),
        .sync          (sync_if.dst),
        .warn_active_o (warn_active)
    );

    panel_status u_panel_status (
        .clk27             (clk27),
        .po_reset_n        (po_reset_n),
        .warn_active_i     (warn_active),
        .enable_sc_i       (ctrl.enable_sc),
        .pll_activeclock_i (pll_activeclock_i),
        .sync              (sync_if.dst),
        .led_r_o           (led_r_o),
        .led_g_o           (led_g_o),
        .status_o          (status_o),
        .pll_clkswitch_o   (pll_clkswitch_o)
    );

endmodule

`default_nettype wire

// ==== bench/tb_board_ctrl.sv ====
//------------------------------
// Board control testbench
// Directed and random stimulus, a cycle
// model of the expected behavior and
// assertions that compare against it
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_board_ctrl;

    // Control word bit positions
    localparam int HW_RESET_BIT = 0;
    localparam int ENABLE_SC_BIT = 1;
    localparam int BL_TIME_LSB = 2;
    localparam int BL_ON_BIT = 4;
    localparam int LCD_RS_BIT = 5;
    localparam int LCD_CS_BIT = 6;
    localparam int SD_SS_BIT = 7;
    localparam int REMOTE_BIT = 8;

    localparam int TICKS = 4;
    localparam int WARN_W = 6;
    localparam int HOLD_CYCLES = (1 << WARN_W) - 1;
    // The 3 s backlight run dominates and the short tests fit in the margin
    localparam int BL_CYCLES = 3000 * TICKS;
    localparam int MAX_CYCLES = 2 * BL_CYCLES + 6000;

    logic        clk27 = 1'b0;
    logic        po_reset_n;
    logic [31:0] sys_ctrl_i;
    logic [1:0]  btn_i;
    logic [1:0]  cfg_i;
    logic        vsync_i;
    logic        resync_strobe_i;
    logic        pll_locked_i;
    logic        pll_areset_i;
    logic        pll_activeclock_i;
    logic [4:0]  status_o;
    logic        led_r_o;
    logic        led_g_o;
    logic        lcd_bl_o;
    logic        lcd_cs_n_o;
    logic        lcd_rs_o;
    logic        sd_ss_n_o;
    logic        hw_reset_n_o;
    logic        pll_clkswitch_o;

    integer      seed;
    int          cycle_count = 0;

    // Reference model state
    int          since_reset;
    logic [1:0]  btn_d1;
    logic [1:0]  btn_d2;
    logic        vflag_d1;
    logic        vflag_d2;
    logic        switch_exp;
    logic [1:0]  cfg_model;
    logic        cfg_taken;
    logic        strobe_q;
    logic [2:0]  edge_pipe;
    int          resync_left;
    int          pll_left;
    logic        remote_q;
    int          quiet;
    logic [1:0]  bl_time_q;
    logic        armed;
    logic        exp_led_r;
    logic        exp_led_g;

    always #20 clk27 = ~clk27;

    board_ctrl #(
        .TICKS_PER_MS (TICKS),
        .WARN_W       (WARN_W)
    ) dut0 (
        .clk27             (clk27),
        .po_reset_n        (po_reset_n),
        .sys_ctrl_i        (sys_ctrl_i),
        .btn_i             (btn_i),
        .cfg_i             (cfg_i),
        .vsync_i           (vsync_i),
        .resync_strobe_i   (resync_strobe_i),
        .pll_locked_i      (pll_locked_i),
        .pll_areset_i      (pll_areset_i),
        .pll_activeclock_i (pll_activeclock_i),
        .status_o          (status_o),
        .led_r_o           (led_r_o),
        .led_g_o           (led_g_o),
        .lcd_bl_o          (lcd_bl_o),
        .lcd_cs_n_o        (lcd_cs_n_o),
        .lcd_rs_o          (lcd_rs_o),
        .sd_ss_n_o         (sd_ss_n_o),
        .hw_reset_n_o      (hw_reset_n_o),
        .pll_clkswitch_o   (pll_clkswitch_o)
    );

    task automatic value_error(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("FAILED %s expected %0h actual %0h", test_name, expected, actual);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("ERROR %s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    always @(posedge clk27) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
            abort_run($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
    end

    // Cycle model clocked on the same edges as the DUT
    always @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            since_reset <= 0;
            btn_d1 <= '0;
            btn_d2 <= '0;
            vflag_d1 <= 1'b0;
            vflag_d2 <= 1'b0;
            switch_exp <= 1'b0;
            cfg_model <= '0;
            cfg_taken <= 1'b0;
            strobe_q <= 1'b0;
            edge_pipe <= '0;
            resync_left <= 0;
            pll_left <= 0;
            remote_q <= 1'b0;
            quiet <= 0;
            bl_time_q <= '0;
        end else begin
            since_reset <= since_reset + 1;
            btn_d1 <= btn_i;
            btn_d2 <= btn_d1;
            vflag_d1 <= ~vsync_i;
            vflag_d2 <= vflag_d1;
            switch_exp <= (pll_activeclock_i != sys_ctrl_i[ENABLE_SC_BIT]);
            if (!cfg_taken)
                cfg_model <= cfg_i;
            cfg_taken <= 1'b1;
            // Rising edge seen 4 cycles after the input moves
            strobe_q <= resync_strobe_i;
            edge_pipe <= {edge_pipe[1:0], resync_strobe_i & ~strobe_q};
            if (sys_ctrl_i[ENABLE_SC_BIT]) begin
                if (edge_pipe[2])
                    resync_left <= HOLD_CYCLES;
                else if (resync_left > 0)
                    resync_left <= resync_left - 1;
            end
            // Remaining hold counted from the cycle lock returns
            if (!pll_areset_i && !pll_locked_i)
                pll_left <= HOLD_CYCLES;
            else if (pll_left > 0)
                pll_left <= pll_left - 1;
            remote_q <= sys_ctrl_i[REMOTE_BIT];
            if (sys_ctrl_i[REMOTE_BIT] != remote_q)
                quiet <= 0;
            else
                quiet <= quiet + 1;
            bl_time_q <= sys_ctrl_i[BL_TIME_LSB +: 2];
        end
    end

    assign armed = po_reset_n && (since_reset >= 3);
    assign exp_led_r = (resync_left != 0) || (pll_left != 0);
    assign exp_led_g = !exp_led_r || cfg_model[1];

    reset_idle_chk: assert property (@(posedge clk27)
        (!po_reset_n && cycle_count > 1) |-> (!led_r_o && !pll_clkswitch_o))
        else value_error("reset_idle", 32'd0,
                         {30'd0, $sampled(led_r_o), $sampled(pll_clkswitch_o)});

    strap_chk: assert property (@(posedge clk27) disable iff (!po_reset_n)
        armed |-> (status_o[2] == cfg_model[0]))
        else value_error("strap_latch", $sampled(cfg_model[0]), $sampled(status_o[2]));

    btn_chk: assert property (@(posedge clk27) disable iff (!po_reset_n)
        armed |-> (status_o[1:0] == btn_d2))
        else value_error("btn_sync", $sampled(btn_d2), $sampled(status_o[1:0]));

    vsync_chk: assert property (@(posedge clk27) disable iff (!po_reset_n)
        armed |-> (status_o[4] == vflag_d2))
        else value_error("vsync_sync", $sampled(vflag_d2), $sampled(status_o[4]));

    led_r_chk: assert property (@(posedge clk27) disable iff (!po_reset_n)
        armed |-> (led_r_o == exp_led_r))
        else value_error("led_r", $sampled(exp_led_r), $sampled(led_r_o));

    led_g_chk: assert property (@(posedge clk27) disable iff (!po_reset_n)
        armed |-> (led_g_o == exp_led_g))
        else value_error("led_g", $sampled(exp_led_g), $sampled(led_g_o));

    bl_gate_chk: assert property (@(posedge clk27)
        !sys_ctrl_i[BL_ON_BIT] |-> !lcd_bl_o)
        else value_error("bl_gated_off", 32'd0, $sampled(lcd_bl_o));

    bl_never_chk: assert property (@(posedge clk27) disable iff (!po_reset_n)
        (armed && sys_ctrl_i[BL_ON_BIT] && bl_time_q == 2'd0) |-> lcd_bl_o)
        else value_error("bl_off_setting", 32'd1, $sampled(lcd_bl_o));

    // Window of a few cycles around 3000 ms
    bl_early_chk: assert property (@(posedge clk27) disable iff (!po_reset_n)
        (armed && sys_ctrl_i[BL_ON_BIT] && bl_time_q == 2'd1 && quiet >= 1
         && quiet < BL_CYCLES - 2) |-> lcd_bl_o)
        else value_error("bl_before_timeout", 32'd1, $sampled(lcd_bl_o));

    bl_late_chk: assert property (@(posedge clk27) disable iff (!po_reset_n)
        (armed && sys_ctrl_i[BL_ON_BIT] && bl_time_q == 2'd1
         && quiet > BL_CYCLES + 4) |-> !lcd_bl_o)
        else value_error("bl_after_timeout", 32'd0, $sampled(lcd_bl_o));

    decode_chk: assert property (@(posedge clk27)
        {lcd_cs_n_o, lcd_rs_o, sd_ss_n_o, hw_reset_n_o} ==
        {sys_ctrl_i[LCD_CS_BIT], sys_ctrl_i[LCD_RS_BIT], sys_ctrl_i[SD_SS_BIT],
         sys_ctrl_i[HW_RESET_BIT]})
        else value_error("ctrl_decode",
                         {28'd0, $sampled(sys_ctrl_i[LCD_CS_BIT]),
                          $sampled(sys_ctrl_i[LCD_RS_BIT]),
                          $sampled(sys_ctrl_i[SD_SS_BIT]),
                          $sampled(sys_ctrl_i[HW_RESET_BIT])},
                         {28'd0, $sampled(lcd_cs_n_o), $sampled(lcd_rs_o),
                          $sampled(sd_ss_n_o), $sampled(hw_reset_n_o)});

    switch_chk: assert property (@(posedge clk27) disable iff (!po_reset_n)
        armed |-> (pll_clkswitch_o == switch_exp))
        else value_error("pll_clkswitch", $sampled(switch_exp), $sampled(pll_clkswitch_o));

    activeclk_chk: assert property (@(posedge clk27)
        status_o[3] == pll_activeclock_i)
        else value_error("status_activeclock", $sampled(pll_activeclock_i),
                         $sampled(status_o[3]));

    // Clock edges with fresh random buttons and vsync on each
    task automatic advance(input int cycles);
        repeat (cycles) begin
            @(posedge clk27);
            btn_i <= 2'($random(seed));
            vsync_i <= 1'($random(seed));
        end
    endtask

    task automatic wait_led_r(input logic level, input int limit);
        int n;
        n = 0;
        while (led_r_o !== level && n < limit) begin
            advance(1);
            n++;
        end
        if (led_r_o !== level)
            abort_run($sformatf("led_r_o did not reach %0b in %0d cycles", level, limit));
    endtask

    task automatic wait_bl(input logic level, input int limit);
        int n;
        n = 0;
        while (lcd_bl_o !== level && n < limit) begin
            advance(1);
            n++;
        end
        if (lcd_bl_o !== level)
            abort_run($sformatf("lcd_bl_o did not reach %0b in %0d cycles", level, limit));
    endtask

    task automatic pulse_resync();
        resync_strobe_i <= 1'b1;
        advance(3);
        resync_strobe_i <= 1'b0;
    endtask

    initial begin
        seed = 32'ha70f6642;
        po_reset_n = 1'b0;
        sys_ctrl_i = 32'h0000_00c1;
        btn_i = 2'b00;
        cfg_i = 2'b01;
        vsync_i = 1'b1;
        resync_strobe_i = 1'b0;
        pll_locked_i = 1'b1;
        pll_areset_i = 1'b0;
        pll_activeclock_i = 1'b0;
        advance(5);
        po_reset_n <= 1'b1;
        // Straps move once latched
        advance(3);
        cfg_i <= 2'b10;
        advance(200);

        // Resync hold with scaling on and then off
        sys_ctrl_i[ENABLE_SC_BIT] <= 1'b1;
        advance(4);
        pulse_resync();
        wait_led_r(1'b1, 8);
        wait_led_r(1'b0, HOLD_CYCLES + 8);
        sys_ctrl_i[ENABLE_SC_BIT] <= 1'b0;
        advance(4);
        pulse_resync();
        advance(20);

        // Second reset with strap bit 1 high keeps green lit
        cfg_i <= 2'b11;
        po_reset_n <= 1'b0;
        advance(5);
        po_reset_n <= 1'b1;
        advance(3);
        cfg_i <= 2'b00;
        sys_ctrl_i[ENABLE_SC_BIT] <= 1'b1;
        advance(4);
        pulse_resync();
        wait_led_r(1'b1, 8);
        wait_led_r(1'b0, HOLD_CYCLES + 8);

        // PLL lock loss followed by a loss under PLL reset
        pll_locked_i <= 1'b0;
        advance(10);
        wait_led_r(1'b1, 2);
        pll_locked_i <= 1'b1;
        wait_led_r(1'b0, HOLD_CYCLES + 8);
        pll_areset_i <= 1'b1;
        pll_locked_i <= 1'b0;
        advance(20);
        pll_areset_i <= 1'b0;
        pll_locked_i <= 1'b1;
        advance(10);

        // Backlight at 3 s restarted by a remote event
        sys_ctrl_i[BL_TIME_LSB +: 2] <= 2'd1;
        sys_ctrl_i[BL_ON_BIT] <= 1'b1;
        sys_ctrl_i[REMOTE_BIT] <= ~sys_ctrl_i[REMOTE_BIT];
        wait_bl(1'b1, 6);
        wait_bl(1'b0, BL_CYCLES + 16);
        sys_ctrl_i[BL_TIME_LSB +: 2] <= 2'd0;
        wait_bl(1'b1, 6);
        advance(50);
        sys_ctrl_i[BL_TIME_LSB +: 2] <= 2'd1;
        wait_bl(1'b0, 6);
        sys_ctrl_i[REMOTE_BIT] <= ~sys_ctrl_i[REMOTE_BIT];
        wait_bl(1'b1, 6);
        advance(20);
        sys_ctrl_i[BL_ON_BIT] <= 1'b0;
        advance(10);

        // Random control words and active clock
        repeat (200) begin
            sys_ctrl_i <= $random(seed);
            pll_activeclock_i <= 1'($random(seed));
            advance(1);
        end
        advance(5);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/board_pkg.sv
logic/ctrl_sync_if.sv
logic/input_sync.sv
logic/backlight_timer.sv
logic/sync_warn.sv
logic/panel_status.sv
logic/board_ctrl.sv
bench/tb_board_ctrl.sv

// ==== Bender.yml ====
package:
  name: board_ctrl

sources:
  # Design, in compile order
  - logic/board_pkg.sv
  - logic/ctrl_sync_if.sv
  - logic/input_sync.sv
  - logic/backlight_timer.sv
  - logic/sync_warn.sv
  - logic/panel_status.sv
  - logic/board_ctrl.sv

  # Testbench
  - target: test
    files:
      - bench/tb_board_ctrl.sv
